//--- cr_map_pkg.sv
package cr_map_pkg;

	localparam int register_size = 32;
	localparam int counter_width = 64;

	typedef logic [register_size - 1 : 0] register_t;

	// Register numbering shared by the core and host sides
	typedef enum logic [15 : 0] {
		tile_id_idx         = 16'd0,
		core_id_idx         = 16'd1,
		thread_id_idx       = 16'd2,
		global_id_idx       = 16'd3,
		gcounter_low_idx    = 16'd4,
		gcounter_high_idx   = 16'd5,
		thread_en_idx       = 16'd6,
		miss_data_idx       = 16'd7,
		miss_instr_idx      = 16'd8,
		pc_idx              = 16'd9,
		trap_reason_idx     = 16'd10,
		thread_status_idx   = 16'd11,
		argc_idx            = 16'd12,
		argv_idx            = 16'd13,
		thread_numb_idx     = 16'd14,
		cpu_ctrl_idx        = 16'd17,
		uncoherence_map_idx = 16'd19
	} cr_index_t;

	// Host request word, thread in the upper half
	typedef struct packed {
		logic [15 : 0] thread;
		cr_index_t     index;
	} host_cr_req_t;

	typedef struct packed {
		logic          cache_wt;
		logic          interrupt_enable;
		logic          supervisor;
		logic          interrupt_pending;
		logic          interrupt_trigger_mode;
		logic [26 : 0] unused;
	} cpu_ctrl_t;

	// Merged write strobes from both request sides
	typedef struct packed {
		logic         argc;
		logic         argv;
		logic         ctrl;
		logic         status;
		logic         map;
		logic [1 : 0] thread;
		register_t    data;
	} cr_write_t;

	// Core request, already classified upstream
	typedef struct packed {
		logic         valid;
		logic         write;
		logic [1 : 0] thread;
		cr_index_t    index;
		register_t    data;
	} core_op_t;

endpackage

//--- core_thread_pkg.sv
package core_thread_pkg;

	import cr_map_pkg::register_t;

	localparam int thread_numb = 4;

	typedef logic [$clog2(thread_numb) - 1 : 0] thread_id_t;
	typedef logic [thread_numb - 1 : 0]         thread_mask_t;

	typedef enum logic [2 : 0] {
		thread_idle     = 3'd0,
		running         = 3'd1,
		waiting_barrier = 3'd2,
		stopped         = 3'd3
	} thread_status_t;

	// Non-coherent region table geometry
	localparam int map_bits = 8;
	localparam int map_size = 4;

	typedef logic [$clog2(map_size) - 1 : 0] map_index_t;

	typedef struct packed {
		logic [map_bits - 1 : 0] start_addr;
		logic [map_bits - 1 : 0] end_addr;
		logic                    valid;
	} region_entry_t;

	// Table write format carried in the core data word
	typedef struct packed {
		logic [12 : 0] unused;
		map_index_t    index;
		region_entry_t entry;
	} map_word_t;

	typedef union packed {
		register_t word;
		map_word_t map;
	} cr_data_u;

endpackage

//--- cr_write_decode.sv
`timescale 1ns/10ps

module cr_write_decode
	import cr_map_pkg::*;
(
	input  core_op_t     core_op,
	input  logic         host_write_valid,
	input  host_cr_req_t host_req,
	input  register_t    host_write_data,
	output cr_write_t    wr
);

	logic core_write;
	logic host_argc;
	logic host_argv;
	logic host_ctrl;
	logic host_any;
	logic core_argc;
	logic core_argv;
	logic core_status;
	logic core_map;

	assign core_write = core_op.valid & core_op.write;

	assign host_argc = host_write_valid & (host_req.index == argc_idx);
	assign host_argv = host_write_valid & (host_req.index == argv_idx);
	assign host_ctrl = host_write_valid & (host_req.index == cpu_ctrl_idx);
	assign host_any  = host_argc | host_argv | host_ctrl;

	// The shared data word belongs to the host in a cycle where it writes
	assign core_argc   = core_write & (core_op.index == argc_idx) & ~host_any;
	assign core_argv   = core_write & (core_op.index == argv_idx) & ~host_any;
	assign core_status = core_write & (core_op.index == thread_status_idx) & ~host_any;
	assign core_map    = core_write & (core_op.index == uncoherence_map_idx) & ~host_any;

	always_comb begin
		wr.argc   = host_argc | core_argc;
		wr.argv   = host_argv | core_argv;
		wr.ctrl   = host_ctrl;
		wr.status = core_status;
		wr.map    = core_map;
		if (host_any) begin
			wr.thread = host_req.thread[1 : 0];
			wr.data   = host_write_data;
		end else begin
			wr.thread = core_op.thread;
			wr.data   = core_op.data;
		end
	end

endmodule

//--- cr_event_counters.sv
`timescale 1ns/10ps

module cr_event_counters
	import cr_map_pkg::*;
(
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         enable,
	input  logic                         ldst_miss,
	input  logic                         inst_miss,
	output logic [counter_width - 1 : 0] global_counter,
	output register_t                    data_miss_count,
	output register_t                    instr_miss_count
);

	// Cycles since reset, only while the core is enabled
	always_ff @(posedge clk, posedge reset) begin
		if (reset)
			global_counter <= '0;
		else if (enable)
			global_counter <= global_counter + 1'b1;
	end

	// L1 data cache misses
	always_ff @(posedge clk, posedge reset) begin
		if (reset)
			data_miss_count <= '0;
		else if (ldst_miss)
			data_miss_count <= data_miss_count + 1'b1;
	end

	// L1 instruction cache misses
	always_ff @(posedge clk, posedge reset) begin
		if (reset)
			instr_miss_count <= '0;
		else if (inst_miss)
			instr_miss_count <= instr_miss_count + 1'b1;
	end

endmodule

//--- cr_thread_state.sv
`timescale 1ns/10ps

module cr_thread_state
	import cr_map_pkg::*, core_thread_pkg::*;
(
	input  logic           clk,
	input  logic           reset,
	input  cr_write_t      wr,
	input  thread_mask_t   release_thread,
	input  logic           trap_en,
	input  thread_id_t     trap_thread,
	input  register_t      trap_reason,
	output thread_status_t thread_status [thread_numb],
	output register_t      trap_regs [thread_numb],
	output register_t      argc,
	output register_t      argv,
	output cpu_ctrl_t      ctrl
);

	thread_status_t status_reg [thread_numb];

	for (genvar t = 0; t < thread_numb; t++) begin : gen_thread
		always_ff @(posedge clk, posedge reset) begin
			if (reset)
				status_reg[t] <= thread_idle;
			else if (wr.status && wr.thread == thread_id_t'(t))
				status_reg[t] <= thread_status_t'(wr.data[2 : 0]);
		end

		// Trap cause from the rollback logic
		always_ff @(posedge clk, posedge reset) begin
			if (reset)
				trap_regs[t] <= '0;
			else if (trap_en && trap_thread == thread_id_t'(t))
				trap_regs[t] <= trap_reason;
		end

		// Held at the barrier until released
		assign thread_status[t] = release_thread[t] ? status_reg[t] : waiting_barrier;
	end

	// Kernel argument registers, filled by host or boot code
	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			argc <= '0;
			argv <= '0;
		end else begin
			if (wr.argc)
				argc <= wr.data;
			if (wr.argv)
				argv <= wr.data;
		end
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset)
			ctrl <= '0;
		else if (wr.ctrl)
			ctrl <= cpu_ctrl_t'(wr.data);
	end

endmodule

//--- cr_coherence_map.sv
`timescale 1ns/10ps

module cr_coherence_map
	import cr_map_pkg::*, core_thread_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  cr_write_t wr,
	input  register_t effective_address,
	output logic      uncoherent_area_hit
);

	cr_data_u                  map_data;
	region_entry_t             regions [map_size];
	logic [map_size - 1 : 0]   hits;
	logic [map_bits - 1 : 0]   lookup;

	// Write word layout
	//   bits 18..17  entry index
	//   bits 16..9   start
	//   bits 8..1    end
	//   bit 0        valid
	assign map_data.word = wr.data;

	assign lookup = effective_address[register_size - 1 -: map_bits];

	for (genvar r = 0; r < map_size; r++) begin : gen_region
		// Only the valid bit needs clearing, bounds are don't care
		always_ff @(posedge clk, posedge reset) begin
			if (reset)
				regions[r].valid <= 1'b0;
			else if (wr.map && map_data.map.index == map_index_t'(r))
				regions[r] <= map_data.map.entry;
		end

		// Bounds are inclusive on both ends
		assign hits[r] = regions[r].valid
			&& lookup >= regions[r].start_addr
			&& lookup <= regions[r].end_addr;
	end

	assign uncoherent_area_hit = |hits;

endmodule

//--- cr_read_mux.sv
`timescale 1ns/10ps

module cr_read_mux
	import cr_map_pkg::*, core_thread_pkg::*;
#(
	parameter int tile_id = 0,
	parameter int core_id = 4
) (
	input  logic                         clk,
	input  logic                         reset,
	input  core_op_t                     core_op,
	input  logic                         host_read_valid,
	input  host_cr_req_t                 host_req,
	input  logic [counter_width - 1 : 0] global_counter,
	input  register_t                    data_miss_count,
	input  register_t                    instr_miss_count,
	input  thread_status_t               thread_status [thread_numb],
	input  register_t                    trap_regs [thread_numb],
	input  register_t                    argc,
	input  register_t                    argv,
	input  cpu_ctrl_t                    ctrl,
	input  thread_mask_t                 thread_en,
	input  register_t                    current_pc [thread_numb],
	output register_t                    cr_result,
	output register_t                    cr_response
);

	thread_id_t host_thread;

	assign host_thread = thread_id_t'(host_req.thread);

	// Same decode for both sides, only index and thread differ
	function automatic register_t select_reg(cr_index_t index, thread_id_t thread);
		register_t value;
		case (index)
			tile_id_idx:         value = register_t'(tile_id);
			core_id_idx:         value = register_t'(core_id);
			thread_id_idx:       value = register_t'(thread);
			global_id_idx:       value = {16'(tile_id), 8'(core_id), 6'd0, thread};
			gcounter_low_idx:    value = global_counter[31 : 0];
			gcounter_high_idx:   value = global_counter[63 : 32];
			thread_en_idx:       value = register_t'(thread_en);
			miss_data_idx:       value = data_miss_count;
			miss_instr_idx:      value = instr_miss_count;
			pc_idx:              value = current_pc[thread];
			trap_reason_idx:     value = trap_regs[thread];
			thread_status_idx:   value = register_t'(thread_status[thread]);
			argc_idx:            value = argc;
			argv_idx:            value = argv;
			thread_numb_idx:     value = register_t'(thread_numb);
			cpu_ctrl_idx:        value = register_t'(ctrl);
			// Region table is write only
			uncoherence_map_idx: value = '0;
			default:             value = '0;
		endcase
		return value;
	endfunction

	// Core side answers in the same cycle
	always_comb begin
		cr_result = select_reg(core_op.index, core_op.thread);
	end

	// Host side is registered and held until the next read
	always_ff @(posedge clk, posedge reset) begin
		if (reset)
			cr_response <= '0;
		else if (host_read_valid)
			cr_response <= select_reg(host_req.index, host_thread);
	end

endmodule

//--- control_register.sv
`timescale 1ns/10ps

module control_register
	import cr_map_pkg::*, core_thread_pkg::*;
#(
	parameter int tile_id = 0,
	parameter int core_id = 4
) (
	input  logic         clk,
	input  logic         reset,
	input  logic         enable,

	// Host side
	input  logic         host_read_valid,
	input  logic         host_write_valid,
	input  host_cr_req_t host_req,
	input  register_t    host_write_data,
	output register_t    cr_response,

	// Core side
	input  core_op_t     core_op,
	output register_t    cr_result,
	input  register_t    current_pc [thread_numb],
	input  thread_mask_t release_thread,
	input  thread_mask_t thread_en,

	// Events and traps
	input  logic         inst_miss,
	input  logic         ldst_miss,
	input  logic         trap_en,
	input  thread_id_t   trap_thread,
	input  register_t    trap_reason,

	// Coherence lookup and configuration
	input  register_t    effective_address,
	output logic         uncoherent_area_hit,
	output logic         cr_ctrl_cache_wt
);

	cr_write_t                    wr;
	logic [counter_width - 1 : 0] global_counter;
	register_t                    data_miss_count;
	register_t                    instr_miss_count;
	thread_status_t               thread_status [thread_numb];
	register_t                    trap_regs [thread_numb];
	register_t                    argc;
	register_t                    argv;
	cpu_ctrl_t                    ctrl;

	cr_write_decode u_write_decode (
		.core_op          (core_op),
		.host_write_valid (host_write_valid),
		.host_req         (host_req),
		.host_write_data  (host_write_data),
		.wr               (wr)
	);

	cr_event_counters u_event_counters (
		.clk              (clk),
		.reset            (reset),
		.enable           (enable),
		.ldst_miss        (ldst_miss),
		.inst_miss        (inst_miss),
		.global_counter   (global_counter),
		.data_miss_count  (data_miss_count),
		.instr_miss_count (instr_miss_count)
	);

	cr_thread_state u_thread_state (
		.clk            (clk),
		.reset          (reset),
		.wr             (wr),
		.release_thread (release_thread),
		.trap_en        (trap_en),
		.trap_thread    (trap_thread),
		.trap_reason    (trap_reason),
		.thread_status  (thread_status),
		.trap_regs      (trap_regs),
		.argc           (argc),
		.argv           (argv),
		.ctrl           (ctrl)
	);

	cr_coherence_map u_coherence_map (
		.clk                 (clk),
		.reset               (reset),
		.wr                  (wr),
		.effective_address   (effective_address),
		.uncoherent_area_hit (uncoherent_area_hit)
	);

	cr_read_mux #(
		.tile_id (tile_id),
		.core_id (core_id)
	) u_read_mux (
		.clk              (clk),
		.reset            (reset),
		.core_op          (core_op),
		.host_read_valid  (host_read_valid),
		.host_req         (host_req),
		.global_counter   (global_counter),
		.data_miss_count  (data_miss_count),
		.instr_miss_count (instr_miss_count),
		.thread_status    (thread_status),
		.trap_regs        (trap_regs),
		.argc             (argc),
		.argv             (argv),
		.ctrl             (ctrl),
		.thread_en        (thread_en),
		.current_pc       (current_pc),
		.cr_result        (cr_result),
		.cr_response      (cr_response)
	);

	// Write-through mode for the data cache
	assign cr_ctrl_cache_wt = ctrl.cache_wt;

endmodule

//--- control_register_asserts.sv
`timescale 1ns/10ps

module control_register_asserts
	import cr_map_pkg::*;
(
	input logic      clk,
	input logic      reset,
	input logic      host_read_valid,
	input core_op_t  core_op,
	input register_t cr_response,
	input logic      cr_ctrl_cache_wt,
	input logic      uncoherent_area_hit
);

	logic map_written;

	// Set once the core has touched the region table
	always_ff @(posedge clk, posedge reset) begin
		if (reset)
			map_written <= 1'b0;
		else if (core_op.valid && core_op.write && core_op.index == uncoherence_map_idx)
			map_written <= 1'b1;
	end

	reset_values: assert property (@(posedge clk)
		$fell(reset) |-> cr_response == '0 && !cr_ctrl_cache_wt)
		else $error("host response or cache write-through not clear after reset");

	// Response only moves after a host read strobe
	response_hold: assert property (@(posedge clk) disable iff (reset)
		!$past(host_read_valid) |-> $stable(cr_response))
		else $error("host response changed without a host read");

	no_hit_before_map: assert property (@(posedge clk) disable iff (reset)
		!map_written |-> !uncoherent_area_hit)
		else $error("region hit raised before any region table write");

endmodule

bind control_register control_register_asserts u_asserts (
	.clk                 (clk),
	.reset               (reset),
	.host_read_valid     (host_read_valid),
	.core_op             (core_op),
	.cr_response         (cr_response),
	.cr_ctrl_cache_wt    (cr_ctrl_cache_wt),
	.uncoherent_area_hit (uncoherent_area_hit)
);

//--- control_register_tb.sv
`timescale 1ns/10ps

module control_register_tb
	import cr_map_pkg::*, core_thread_pkg::*;
();

	localparam int tb_tile_id = 3;
	localparam int tb_core_id = 5;
	localparam int reset_cycles = 4;

	typedef enum logic [3:0] {
		op_host_write, op_host_read, op_core_write, op_core_read, op_both_write,
		op_miss_pulse, op_trap_pulse, op_addr_lookup, op_wt_check
	} op_kind_t;

	typedef struct packed {
		op_kind_t     kind;
		cr_index_t    index;
		thread_id_t   thread;
		register_t    data;
		thread_mask_t release_bits;
		register_t    expected;
	} step_t;

	logic         clk;
	logic         reset;
	logic         enable;
	logic         host_read_valid;
	logic         host_write_valid;
	host_cr_req_t host_req;
	register_t    host_write_data;
	register_t    cr_response;
	core_op_t     core_op;
	register_t    cr_result;
	register_t    current_pc [thread_numb];
	thread_mask_t release_thread;
	thread_mask_t thread_en;
	logic         inst_miss;
	logic         ldst_miss;
	logic         trap_en;
	thread_id_t   trap_thread;
	register_t    trap_reason;
	register_t    effective_address;
	logic         uncoherent_area_hit;
	logic         cr_ctrl_cache_wt;

	step_t        steps [$];
	integer       seed = 32'h6f51_d71d;
	int           step_num;
	int           cycle_count;
	int           cycle_limit;
	logic [63:0]  model_gcount;
	register_t    model_dmiss;
	register_t    model_imiss;

	control_register #(
		.tile_id (tb_tile_id),
		.core_id (tb_core_id)
	) dut (
		.clk                 (clk),
		.reset               (reset),
		.enable              (enable),
		.host_read_valid     (host_read_valid),
		.host_write_valid    (host_write_valid),
		.host_req            (host_req),
		.host_write_data     (host_write_data),
		.cr_response         (cr_response),
		.core_op             (core_op),
		.cr_result           (cr_result),
		.current_pc          (current_pc),
		.release_thread      (release_thread),
		.thread_en           (thread_en),
		.inst_miss           (inst_miss),
		.ldst_miss           (ldst_miss),
		.trap_en             (trap_en),
		.trap_thread         (trap_thread),
		.trap_reason         (trap_reason),
		.effective_address   (effective_address),
		.uncoherent_area_hit (uncoherent_area_hit),
		.cr_ctrl_cache_wt    (cr_ctrl_cache_wt)
	);

	always #10 clk = ~clk;

	// Counter model, fed by the enable and miss levels driven below
	always @(posedge clk, posedge reset) begin
		if (reset) begin
			model_gcount <= '0;
			model_dmiss  <= '0;
			model_imiss  <= '0;
		end else begin
			if (enable)
				model_gcount <= model_gcount + 1'b1;
			if (ldst_miss)
				model_dmiss <= model_dmiss + 1'b1;
			if (inst_miss)
				model_imiss <= model_imiss + 1'b1;
		end
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("Timeout after %0d cycles, the stimulus table did not complete", cycle_count);
			$display("Regression failed");
			$fatal(1, "watchdog expired");
		end
	end

	task automatic check_word(input string name, input register_t got, input register_t want);
		if (got !== want) begin
			$display("FAIL %s at step %0d got 0x%h expected 0x%h", name, step_num, got, want);
			$display("Regression failed");
			$fatal(1, "word mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic want);
		if (got !== want) begin
			$display("FAIL %s at step %0d got 0x%h expected 0x%h", name, step_num, got, want);
			$display("Regression failed");
			$fatal(1, "flag mismatch");
		end
	endtask

	// Global id layout is tile in the top half, core in the next byte
	function automatic register_t global_id_word(input thread_id_t thread);
		return register_t'((tb_tile_id << 16) | (tb_core_id << 8) | thread);
	endfunction

	function automatic register_t map_word(input logic [1:0] slot, input logic [7:0] first,
			input logic [7:0] last, input logic valid);
		return {13'd0, slot, first, last, valid};
	endfunction

	function automatic register_t ctrl_word(input logic wt);
		cpu_ctrl_t c;
		c = '0;
		c.cache_wt = wt;
		c.supervisor = 1'b1;
		return register_t'(c);
	endfunction

	// Counters come from the model, all else from the table
	function automatic register_t expected_value(input step_t s);
		case (s.index)
			gcounter_low_idx: return model_gcount[31:0];
			miss_data_idx:    return model_dmiss;
			miss_instr_idx:   return model_imiss;
			default:          return s.expected;
		endcase
	endfunction

	task automatic add_step(input op_kind_t kind, input cr_index_t index, input thread_id_t thread,
			input register_t data, input thread_mask_t release_bits, input register_t expected);
		step_t s;
		s = '{kind, index, thread, data, release_bits, expected};
		steps.push_back(s);
	endtask

	task automatic clear_strobes();
		host_read_valid  = 1'b0;
		host_write_valid = 1'b0;
		core_op          = '0;
		trap_en          = 1'b0;
		ldst_miss        = 1'b0;
		inst_miss        = 1'b0;
	endtask

	task automatic fill_table();
		// Identity registers
		add_step(op_core_read, tile_id_idx, 2'd0, '0, '1, 32'd3);
		add_step(op_core_read, core_id_idx, 2'd0, '0, '1, 32'd5);
		add_step(op_core_read, thread_numb_idx, 2'd0, '0, '1, 32'd4);
		add_step(op_core_read, thread_id_idx, 2'd2, '0, '1, 32'd2);
		add_step(op_core_read, global_id_idx, 2'd1, '0, '1, global_id_word(2'd1));
		add_step(op_host_read, tile_id_idx, 2'd0, '0, '1, 32'd3);
		add_step(op_host_read, core_id_idx, 2'd0, '0, '1, 32'd5);
		add_step(op_host_read, global_id_idx, 2'd2, '0, '1, global_id_word(2'd2));
		add_step(op_host_read, thread_numb_idx, 2'd0, '0, '1, 32'd4);
		add_step(op_host_read, thread_id_idx, 2'd3, '0, '1, 32'd3);
		add_step(op_host_read, cr_index_t'(16'd15), 2'd0, '0, '1, 32'd0);
		add_step(op_core_read, pc_idx, 2'd1, '0, '1, 32'h0040_0010);
		// Argument registers, host wins a shared cycle
		add_step(op_host_write, argc_idx, 2'd0, 32'h0000_0011, '1, '0);
		add_step(op_core_read, argc_idx, 2'd0, '0, '1, 32'h0000_0011);
		add_step(op_core_write, argv_idx, 2'd0, 32'hbeef_0002, '1, '0);
		add_step(op_host_read, argv_idx, 2'd0, '0, '1, 32'hbeef_0002);
		add_step(op_both_write, argc_idx, 2'd0, 32'haaaa_0001, '1, '0);
		add_step(op_host_read, argc_idx, 2'd0, '0, '1, 32'haaaa_0001);
		add_step(op_both_write, argv_idx, 2'd0, 32'h5555_0003, '1, '0);
		add_step(op_core_read, argv_idx, 2'd0, '0, '1, 32'h5555_0003);
		// Thread status, barrier and trap
		add_step(op_core_write, thread_status_idx, 2'd1, register_t'(running), '1, '0);
		add_step(op_core_read, thread_status_idx, 2'd1, '0, '1, register_t'(running));
		add_step(op_core_read, thread_status_idx, 2'd1, '0, 4'b1101, register_t'(waiting_barrier));
		add_step(op_host_read, thread_status_idx, 2'd1, '0, 4'b1101, register_t'(waiting_barrier));
		add_step(op_core_read, thread_status_idx, 2'd0, '0, '1, register_t'(thread_idle));
		add_step(op_trap_pulse, trap_reason_idx, 2'd2, 32'h0000_00c3, '1, '0);
		add_step(op_core_read, trap_reason_idx, 2'd2, '0, '1, 32'h0000_00c3);
		add_step(op_host_read, trap_reason_idx, 2'd1, '0, '1, 32'd0);
		// Event counters
		add_step(op_host_read, gcounter_low_idx, 2'd0, '0, '1, '0);
		repeat (8) add_step(op_miss_pulse, tile_id_idx, 2'd0, '0, '1, '0);
		add_step(op_core_read, miss_data_idx, 2'd0, '0, '1, '0);
		add_step(op_host_read, miss_instr_idx, 2'd0, '0, '1, '0);
		add_step(op_host_read, gcounter_low_idx, 2'd0, '0, '1, '0);
		add_step(op_core_read, gcounter_high_idx, 2'd0, '0, '1, 32'd0);
		// Region table, entry 1 left invalid
		add_step(op_addr_lookup, tile_id_idx, 2'd0, 32'h1000_0000, '1, 32'd0);
		add_step(op_core_write, uncoherence_map_idx, 2'd0, map_word(2'd0, 8'h10, 8'h1f, 1'b1), '1, '0);
		add_step(op_core_write, uncoherence_map_idx, 2'd0, map_word(2'd2, 8'h80, 8'h80, 1'b1), '1, '0);
		add_step(op_core_write, uncoherence_map_idx, 2'd0, map_word(2'd1, 8'h40, 8'h7f, 1'b0), '1, '0);
		add_step(op_addr_lookup, tile_id_idx, 2'd0, 32'h1000_0000, '1, 32'd1);
		add_step(op_addr_lookup, tile_id_idx, 2'd0, 32'h1fff_ffff, '1, 32'd1);
		add_step(op_addr_lookup, tile_id_idx, 2'd0, 32'h0fff_ffff, '1, 32'd0);
		add_step(op_addr_lookup, tile_id_idx, 2'd0, 32'h2000_0000, '1, 32'd0);
		add_step(op_addr_lookup, tile_id_idx, 2'd0, 32'h80ff_ffff, '1, 32'd1);
		add_step(op_addr_lookup, tile_id_idx, 2'd0, 32'h8100_0000, '1, 32'd0);
		add_step(op_addr_lookup, tile_id_idx, 2'd0, 32'h5000_0000, '1, 32'd0);
		add_step(op_host_read, uncoherence_map_idx, 2'd0, '0, '1, 32'd0);
		// CPU control, only the host may write it
		add_step(op_wt_check, tile_id_idx, 2'd0, '0, '1, 32'd0);
		add_step(op_host_write, cpu_ctrl_idx, 2'd0, ctrl_word(1'b1), '1, '0);
		add_step(op_wt_check, tile_id_idx, 2'd0, '0, '1, 32'd1);
		add_step(op_core_write, cpu_ctrl_idx, 2'd0, 32'd0, '1, '0);
		add_step(op_host_read, cpu_ctrl_idx, 2'd0, '0, '1, ctrl_word(1'b1));
		add_step(op_core_read, cpu_ctrl_idx, 2'd0, '0, '1, ctrl_word(1'b1));
	endtask

	task automatic apply_step(input step_t s);
		register_t   want;
		logic [31:0] rand_bits;
		@(posedge clk);
		#2;
		clear_strobes();
		rand_bits = $random(seed);
		enable = rand_bits[0];
		release_thread = s.release_bits;
		want = expected_value(s);
		case (s.kind)
			op_host_write, op_both_write: begin
				host_write_valid = 1'b1;
				host_req = '{16'(s.thread), s.index};
				host_write_data = s.data;
				if (s.kind == op_both_write)
					core_op = '{1'b1, 1'b1, s.thread, s.index, ~s.data};
			end
			op_core_write: core_op = '{1'b1, 1'b1, s.thread, s.index, s.data};
			op_core_read: begin
				core_op = '{1'b1, 1'b0, s.thread, s.index, 32'd0};
				#10;
				check_word("cr_result", cr_result, want);
			end
			op_host_read: begin
				host_read_valid = 1'b1;
				host_req = '{16'(s.thread), s.index};
				@(posedge clk);
				#2;
				host_read_valid = 1'b0;
				check_word("cr_response", cr_response, want);
			end
			op_miss_pulse: begin
				rand_bits = $random(seed);
				ldst_miss = rand_bits[0];
				inst_miss = rand_bits[1];
			end
			op_trap_pulse: begin
				trap_en = 1'b1;
				trap_thread = s.thread;
				trap_reason = s.data;
			end
			op_addr_lookup: begin
				effective_address = s.data;
				#10;
				check_flag("uncoherent_area_hit", uncoherent_area_hit, want[0]);
			end
			default: begin
				#10;
				check_flag("cr_ctrl_cache_wt", cr_ctrl_cache_wt, want[0]);
			end
		endcase
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		enable = 1'b0;
		clear_strobes();
		host_req = '0;
		host_write_data = '0;
		release_thread = '1;
		thread_en = 4'b1011;
		trap_thread = '0;
		trap_reason = '0;
		effective_address = '0;
		cycle_count = 0;
		for (int t = 0; t < thread_numb; t++)
			current_pc[t] = 32'h0040_0000 | register_t'(t << 4);
		fill_table();
		cycle_limit = 4 * steps.size() + reset_cycles;
		repeat (reset_cycles) @(posedge clk);
		#2;
		reset = 1'b0;
		foreach (steps[i]) begin
			step_num = i;
			apply_step(steps[i]);
		end
		@(posedge clk);
		#2;
		clear_strobes();
		$display("Regression passed");
		$finish;
	end

endmodule

//--- project.f
cr_map_pkg.sv
core_thread_pkg.sv
cr_write_decode.sv
cr_event_counters.sv
cr_thread_state.sv
cr_coherence_map.sv
cr_read_mux.sv
control_register.sv
control_register_asserts.sv
control_register_tb.sv
